// ==== tests/ooo_core_vectors.txt ====
# T name must_stall use_gaps / I op rd rs1 rs2 imm / C rd value, numbers in hex
# op 0 add, 1 sub, 2 and, 3 addi, 4 mul
T independent_alu 0 0
I 3 1 0 0 0012
C 1 00000012
I 3 2 0 0 fff0
C 2 fffffff0
I 3 3 0 0 7fff
C 3 00007fff
I 0 4 1 3 0000
C 4 00008011
I 1 5 1 2 0000
C 5 00000022
I 2 6 2 3 0000
C 6 00007ff0
T raw_chain 1 0
I 3 7 0 0 0003
C 7 00000003
I 0 7 7 7 0000
C 7 00000006
I 3 7 7 0 ffff
C 7 00000005
I 1 8 7 1 0000
C 8 fffffff3
I 2 8 8 2 0000
C 8 fffffff0
I 4 9 8 7 0000
C 9 ffffffb0
I 0 9 9 7 0000
C 9 ffffffb5
T mul_then_alu 0 0
I 4 a 2 3 0000
C a fff80010
I 3 b 0 0 0100
C b 00000100
I 1 c 3 1 0000
C c 00007fed
I 2 d 3 4 0000
C d 00000011
T same_reg_writes 0 0
I 3 e 0 0 0001
C e 00000001
I 0 f e e 0000
C f 00000002
I 3 e 0 0 0010
C e 00000010
I 0 f f e 0000
C f 00000012
I 4 e e f 0000
C e 00000120
I 3 e e 0 0001
C e 00000121
I 1 f e f 0000
C f 0000010f
T mul_burst 1 0
I 4 1 1 1 0000
C 1 00000144
I 4 2 2 2 0000
C 2 00000100
I 4 3 3 3 0000
C 3 3fff0001
I 4 4 4 4 0000
C 4 40110121
I 4 5 5 5 0000
C 5 00000484
I 4 6 6 6 0000
C 6 3ff00100
I 4 7 7 7 0000
C 7 00000019
I 4 b b b 0000
C b 00010000
I 4 c b c 0000
C c 7fed0000
I 4 d c d 0000
C d 7ebd0000
T random_gaps 0 1
I 3 1 0 0 1234
C 1 00001234
I 4 2 1 1 0000
C 2 014b5a90
I 1 3 2 1 0000
C 3 014b485c
I 3 1 1 0 8000
C 1 ffff9234
I 2 4 3 1 0000
C 4 014b0014
I 4 5 4 3 0000
C 5 a8d5a730
I 0 6 5 2 0000
C 6 aa2101c0
I 3 7 6 0 0040
C 7 aa210200

// ==== ooo_core.f ====
verilog/ooo_pkg.sv
verilog/regfile_module.sv
verilog/rob.sv
verilog/dispatch.sv
verilog/exec_unit.sv
verilog/ooo_core.sv
tests/ooo_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
		-f ooo_core.f -o ooo_core_sim
	./obj_dir/ooo_core_sim | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== tests/ooo_core_tb.sv ====
`timescale 1ns/1ns

module ooo_core_tb import ooo_pkg::*;;

    localparam int rob_depth = 8;

    logic    in_clk;
    logic    in_rst;
    instr_t  in_instr;
    logic    in_instr_valid;
    logic    out_stall;
    commit_t out_commit;

    integer seed = 32'h2aa06161;
    int     errors = 0;
    int     n_commits = 0;
    int     limit = 100;   // raised once the vectors are loaded
    int     cycles;
    bit     stall_seen;

    // vectors, one start index per test plus a closing sentinel
    instr_t          instr_q [$];
    gpr_idx_t        exp_rd [$];
    gpr_t            exp_val [$];
    string           test_name [$];
    int              test_stall [$];
    int              test_gaps [$];
    int              instr_start [$];
    int              exp_start [$];

    ooo_core #(.rob_depth(rob_depth)) dut0 (
        .in_clk         (in_clk),
        .in_rst         (in_rst),
        .in_instr       (in_instr),
        .in_instr_valid (in_instr_valid),
        .out_stall      (out_stall),
        .out_commit     (out_commit)
    );

    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    // ************************************************************
    // vector file
    // ************************************************************
    task automatic load_vectors(output bit ok);
        int               fd;
        int               r;
        int               op_v;
        int               rd_v;
        int               rs1_v;
        int               rs2_v;
        int               imm_v;
        int               stall_v;
        int               gaps_v;
        gpr_t             val_v;
        instr_t           ins;
        logic [8*32-1:0]  tok;
        logic [8*128-1:0] rest;
        ok = 1'b1;
        fd = $fopen("tests/ooo_core_vectors.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    r = $fgets(rest, fd);   // comment line
                end else if (tok == "T") begin
                    r = $fscanf(fd, "%s %d %d", tok, stall_v, gaps_v);
                    test_name.push_back(string'(tok));
                    test_stall.push_back(stall_v);
                    test_gaps.push_back(gaps_v);
                    instr_start.push_back(instr_q.size());
                    exp_start.push_back(exp_rd.size());
                end else if (tok == "I") begin
                    r = $fscanf(fd, "%h %h %h %h %h", op_v, rd_v, rs1_v, rs2_v, imm_v);
                    ins.op  = op_t'(op_v[2:0]);
                    ins.rd  = gpr_idx_t'(rd_v);
                    ins.rs1 = gpr_idx_t'(rs1_v);
                    ins.rs2 = gpr_idx_t'(rs2_v);
                    ins.imm = imm_t'(imm_v);
                    instr_q.push_back(ins);
                end else if (tok == "C") begin
                    r = $fscanf(fd, "%h %h", rd_v, val_v);
                    exp_rd.push_back(gpr_idx_t'(rd_v));
                    exp_val.push_back(val_v);
                end else begin
                    $display("vectors file has a line of unknown kind");
                    ok = 1'b0;
                end
            end
            instr_start.push_back(instr_q.size());
            exp_start.push_back(exp_rd.size());
            $fclose(fd);
        end
    endtask

    // ************************************************************
    // driving
    // ************************************************************
    task automatic send_instr(input instr_t ins);
        while (out_stall) begin   // stall is stable here, it hangs off registers only
            @(posedge in_clk);
            #1;
        end
        in_instr       = ins;
        in_instr_valid = 1'b1;
        @(posedge in_clk);
        #1;
        in_instr_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int gap;
        int i;
        errs_before = errors;
        stall_seen  = 1'b0;
        for (i = instr_start[t]; i < instr_start[t+1]; i++) begin
            send_instr(instr_q[i]);
            if (test_gaps[t] != 0) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    @(posedge in_clk);
                    #1;
                end
            end
        end
        while (n_commits < exp_start[t+1]) begin
            @(posedge in_clk);
            #1;
        end
        if (test_stall[t] != 0) begin
            assert (stall_seen) else begin
                $display("out_stall never rose during test %0s", test_name[t]);
                errors++;
            end
        end
        $display("test %0d %0s: %0d instructions, %0d errors", t + 1, test_name[t],
                 instr_start[t+1] - instr_start[t], errors - errs_before);
    endtask

    // ************************************************************
    // commit monitor, sampled away from the clock edge
    // ************************************************************
    task automatic check_commit();
        logic [tag_field_w-1:0] exp_tag;
        exp_tag = tag_field_w'(n_commits % rob_depth);   // rob slots retire in turn
        assert (n_commits < exp_rd.size()) else begin
            $display("commit of r%0d arrived beyond the expected stream", out_commit.rd);
            errors++;
        end
        assert (out_commit.tag == exp_tag) else begin
            $display("CHECK FAILED out_commit.tag got %h expected %h at commit %0d",
                     out_commit.tag, exp_tag, n_commits);
            errors++;
        end
        if (n_commits < exp_rd.size()) begin
            assert (out_commit.rd == exp_rd[n_commits]) else begin
                $display("CHECK FAILED out_commit.rd got %h expected %h at commit %0d",
                         out_commit.rd, exp_rd[n_commits], n_commits);
                errors++;
            end
            assert (out_commit.value == exp_val[n_commits]) else begin
                $display("CHECK FAILED out_commit.value got %h expected %h at commit %0d",
                         out_commit.value, exp_val[n_commits], n_commits);
                errors++;
            end
        end
        n_commits++;
    endtask

    always @(negedge in_clk) begin
        if (in_rst === 1'b0) begin
            if (out_stall) stall_seen = 1'b1;
            if (out_commit.valid) check_commit();
        end
    end

    initial begin : watchdog
        cycles = 0;
        @(posedge in_clk);
        while (cycles < limit) begin
            @(posedge in_clk);
            cycles++;
        end
        $display("timeout, run stopped after %0d cycles", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        bit ok;
        int t;
        in_rst         = 1'b1;
        in_instr       = '0;
        in_instr_valid = 1'b0;
        load_vectors(ok);
        if (!ok) begin
            $display("could not read the vectors file");
            errors++;
        end
        limit = 20 * instr_q.size() + 100;
        repeat (4) @(posedge in_clk);
        #1;
        in_rst = 1'b0;
        if (ok) begin
            for (t = 0; t < test_name.size(); t++) begin
                run_test(t);
            end
            repeat (10) @(posedge in_clk);   // a stray commit would land here
        end
        $display("%0d tests, %0d commits checked, %0d errors",
                 test_name.size(), n_commits, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog/ooo_core.sv ====
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    localparam int tag_w = tag_bits(rob_depth)
) (
    input  logic    in_clk,
    input  logic    in_rst,
    input  instr_t  in_instr,
    input  logic    in_instr_valid,
    output logic    out_stall,
    output commit_t out_commit
);

    // dispatch <-> regfile
    logic             read_en;
    gpr_idx_t         rd_idx_a;
    gpr_idx_t         rd_idx_b;
    gpr_entry         rd_a;
    gpr_entry         rd_b;
    logic             alloc_valid;
    gpr_idx_t         alloc_rd;
    logic [tag_w-1:0] alloc_tag;

    // dispatch <-> rob
    logic [tag_w-1:0] tail_tag;
    logic             full;
    logic [tag_w-1:0] tag_a;
    logic [tag_w-1:0] tag_b;
    logic             done_a;
    logic             done_b;
    gpr_t             val_a;
    gpr_t             val_b;

    // execute path
    issue_t issue;
    logic   issue_valid;
    wb_t    alu_wb;
    wb_t    mul_wb;

    // ************************************************************
    // blocks
    // ************************************************************
    dispatch #(.rob_depth(rob_depth)) u_dispatch (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .instr       (in_instr),
        .instr_valid (in_instr_valid),
        .stall       (out_stall),
        .read_en     (read_en),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .alloc_tag   (alloc_tag),
        .tail_tag    (tail_tag),
        .full        (full),
        .tag_a       (tag_a),
        .tag_b       (tag_b),
        .done_a      (done_a),
        .done_b      (done_b),
        .val_a       (val_a),
        .val_b       (val_b),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    regfile_module #(.rob_depth(rob_depth)) u_regfile (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .read_en     (read_en),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .alloc_tag   (alloc_tag),
        .commit      (out_commit)   // retire also goes out
    );

    rob #(.rob_depth(rob_depth)) u_rob (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .tail_tag    (tail_tag),
        .full        (full),
        .alu_wb      (alu_wb),
        .mul_wb      (mul_wb),
        .tag_a       (tag_a),
        .tag_b       (tag_b),
        .done_a      (done_a),
        .done_b      (done_b),
        .val_a       (val_a),
        .val_b       (val_b),
        .commit      (out_commit)
    );

    exec_unit #(.rob_depth(rob_depth)) u_exec (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .alu_wb      (alu_wb),
        .mul_wb      (mul_wb)
    );

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    localparam int tag_w = tag_bits(rob_depth)
) (
    input  logic   in_clk,
    input  logic   in_rst,
    input  issue_t issue,
    input  logic   issue_valid,
    output wb_t    alu_wb,
    output wb_t    mul_wb
);

    // partial products of the first multiply stage
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        gpr_t             p_lo;   // a * b[15:0]
        logic [15:0]      p_hi;   // a[15:0] * b[31:16], only low half survives
    } mul_s1_t;

    mul_s1_t mul_s1;
    wb_t     mul_s2;

    // ************************************************************
    // one-cycle alu, result lands in the rob at the next edge
    // ************************************************************
    always_comb begin
        alu_wb.valid = issue_valid && (issue.op != OP_MUL);
        alu_wb.tag   = issue.tag;
        alu_wb.value = '0;
        case (issue.op)
            OP_ADD, OP_ADDI: alu_wb.value = issue.opa + issue.opb;
            OP_SUB:          alu_wb.value = issue.opa - issue.opb;
            OP_AND:          alu_wb.value = issue.opa & issue.opb;
            default:         alu_wb.value = '0;
        endcase
    end

    // ************************************************************
    // multiplier, issue stage, partial products, sum
    // ************************************************************
    always_ff @(posedge in_clk) begin
        mul_s1.tag   <= issue.tag[tag_w-1:0];
        mul_s1.p_lo  <= issue.opa * {16'd0, issue.opb[15:0]};
        mul_s1.p_hi  <= issue.opa[15:0] * issue.opb[31:16];
        mul_s2.tag   <= tag_field_w'(mul_s1.tag);
        mul_s2.value <= mul_s1.p_lo + {mul_s1.p_hi, 16'd0};
        if (in_rst) begin
            mul_s1.valid <= 1'b0;
            mul_s2.valid <= 1'b0;
        end else begin
            mul_s1.valid <= issue_valid && (issue.op == OP_MUL);
            mul_s2.valid <= mul_s1.valid;
        end
    end

    assign mul_wb = mul_s2;

endmodule

// ==== verilog/dispatch.sv ====
`timescale 1ns/1ns

module dispatch import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    localparam int tag_w = tag_bits(rob_depth)
) (
    input  logic             in_clk,
    input  logic             in_rst,
    input  instr_t           instr,
    input  logic             instr_valid,
    output logic             stall,
    // regfile
    output logic             read_en,
    output gpr_idx_t         rd_idx_a,
    output gpr_idx_t         rd_idx_b,
    input  gpr_entry         rd_a,
    input  gpr_entry         rd_b,
    output logic             alloc_valid,
    output gpr_idx_t         alloc_rd,
    output logic [tag_w-1:0] alloc_tag,
    // rob
    input  logic [tag_w-1:0] tail_tag,
    input  logic             full,
    output logic [tag_w-1:0] tag_a,
    output logic [tag_w-1:0] tag_b,
    input  logic             done_a,
    input  logic             done_b,
    input  gpr_t             val_a,
    input  gpr_t             val_b,
    // execute
    output issue_t           issue,
    output logic             issue_valid
);

    instr_t held;
    logic   held_valid;
    logic   a_ok;
    logic   b_ok;
    logic   ready;

    assign read_en  = held_valid;
    assign rd_idx_a = held.rs1;
    assign rd_idx_b = held.rs2;
    assign tag_a    = rd_a.tag[tag_w-1:0];
    assign tag_b    = rd_b.tag[tag_w-1:0];

    // ************************************************************
    // operand select and readiness
    // ************************************************************
    always_comb begin
        a_ok      = !rd_a.busy || done_a;
        issue.opa = rd_a.busy ? val_a : rd_a.value;
        if (held.op == OP_ADDI) begin
            b_ok      = 1'b1;   // rs2 not a source
            issue.opb = {{16{held.imm[15]}}, held.imm};
        end else begin
            b_ok      = !rd_b.busy || done_b;
            issue.opb = rd_b.busy ? val_b : rd_b.value;
        end
        issue.op  = held.op;
        issue.tag = tag_field_w'(tail_tag);
        ready     = held_valid && a_ok && b_ok;
    end

    assign issue_valid = ready && !full;
    assign stall       = full || (held_valid && !ready);

    // rename at issue time
    assign alloc_valid = issue_valid;
    assign alloc_rd    = held.rd;
    assign alloc_tag   = tail_tag;

    // one-entry holding register
    always_ff @(posedge in_clk) begin
        if (instr_valid && !stall) begin
            held <= instr;
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            held_valid <= 1'b0;
        end else if (instr_valid && !stall) begin
            held_valid <= 1'b1;   // may refill in the issue cycle
        end else if (issue_valid) begin
            held_valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/rob.sv ====
`timescale 1ns/1ns

module rob import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    localparam int tag_w = tag_bits(rob_depth)
) (
    input  logic             in_clk,
    input  logic             in_rst,
    input  logic             alloc_valid,
    input  gpr_idx_t         alloc_rd,
    output logic [tag_w-1:0] tail_tag,
    output logic             full,
    input  wb_t              alu_wb,
    input  wb_t              mul_wb,
    input  logic [tag_w-1:0] tag_a,
    input  logic [tag_w-1:0] tag_b,
    output logic             done_a,
    output logic             done_b,
    output gpr_t             val_a,
    output gpr_t             val_b,
    output commit_t          commit
);

    gpr_idx_t         rd_q  [rob_depth];
    gpr_t             val_q [rob_depth];
    logic [rob_depth-1:0] done_q;
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;
    logic             retire;
    logic [tag_w-1:0] alu_idx;
    logic [tag_w-1:0] mul_idx;

    assign alu_idx  = alu_wb.tag[tag_w-1:0];
    assign mul_idx  = mul_wb.tag[tag_w-1:0];
    assign tail_tag = tail;
    assign full     = (count == (tag_w + 1)'(rob_depth));
    assign retire   = (count != '0) && done_q[head];   // head done, goes next edge

    // bypass reads
    assign done_a = done_q[tag_a];
    assign done_b = done_q[tag_b];
    assign val_a  = val_q[tag_a];
    assign val_b  = val_q[tag_b];

    // entry is between head and tail
    function automatic logic live(input logic [tag_w-1:0] tag);
        logic [tag_w-1:0] offset;
        offset = tag - head;
        return {1'b0, offset} < count;
    endfunction

    // ************************************************************
    // entry payload
    // ************************************************************
    always_ff @(posedge in_clk) begin
        if (alloc_valid) begin
            rd_q[tail] <= alloc_rd;
        end
        if (alu_wb.valid) begin
            val_q[alu_idx] <= alu_wb.value;
        end
        if (mul_wb.valid) begin
            val_q[mul_idx] <= mul_wb.value;
        end
    end

    // ************************************************************
    // pointers, done flags and in-order commit
    // ************************************************************
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            done_q <= '0;
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            commit <= '0;
        end else begin
            commit.valid <= retire;
            commit.rd    <= rd_q[head];
            commit.tag   <= tag_field_w'(head);
            commit.value <= val_q[head];
            if (alloc_valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;   // wraps, depth is a power of two
            end
            if (alu_wb.valid) done_q[alu_idx] <= 1'b1;
            if (mul_wb.valid) done_q[mul_idx] <= 1'b1;
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (tag_w + 1)'(alloc_valid) - (tag_w + 1)'(retire);
        end
    end

    a_no_alloc_full: assert property (
        @(posedge in_clk) disable iff (in_rst)
        alloc_valid |-> !full
    ) else $error("rob allocation while full");

    // alu result lands on the same edge that allocates its entry
    a_alu_wb_live: assert property (
        @(posedge in_clk) disable iff (in_rst)
        alu_wb.valid |-> (alloc_valid && alu_idx == tail) ||
                         (live(alu_idx) && !done_q[alu_idx])
    ) else $error("alu writeback to free or done entry %0d", alu_idx);

    a_mul_wb_live: assert property (
        @(posedge in_clk) disable iff (in_rst)
        mul_wb.valid |-> live(mul_idx) && !done_q[mul_idx]
    ) else $error("mul writeback to free or done entry %0d", mul_idx);

endmodule

// ==== verilog/regfile_module.sv ====
`timescale 1ns/1ns

module regfile_module import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    localparam int tag_w = tag_bits(rob_depth)
) (
    input  logic             in_clk,
    input  logic             in_rst,
    // read side, from dispatch
    input  gpr_idx_t         rd_idx_a,
    input  gpr_idx_t         rd_idx_b,
    input  logic             read_en,
    output gpr_entry         rd_a,
    output gpr_entry         rd_b,
    // rename on issue
    input  logic             alloc_valid,
    input  gpr_idx_t         alloc_rd,
    input  logic [tag_w-1:0] alloc_tag,
    // retire from rob
    input  commit_t          commit
);

    gpr_entry gprs [num_gprs];

    // reads are combinational, zero when not enabled
    always_comb begin
        rd_a = '0;
        rd_b = '0;
        if (read_en) begin
            rd_a = gprs[rd_idx_a];
            rd_b = gprs[rd_idx_b];
        end
    end

    // ************************************************************
    // commit and allocation
    // ************************************************************
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < num_gprs; i++) begin
                gprs[i] <= '0;
            end
        end else begin
            if (commit.valid) begin
                gprs[commit.rd].value <= commit.value;
                // a younger writer keeps the register busy
                if (gprs[commit.rd].tag == commit.tag) begin
                    gprs[commit.rd].busy <= 1'b0;
                end
            end
            if (alloc_valid) begin   // wins over a same cycle commit
                gprs[alloc_rd].busy <= 1'b1;
                gprs[alloc_rd].tag  <= tag_field_w'(alloc_tag);
            end
        end
    end

    // rob only retires results that were renamed here
    a_commit_busy: assert property (
        @(posedge in_clk) disable iff (in_rst)
        commit.valid |-> gprs[commit.rd].busy
    ) else $error("commit to r%0d which is not busy", commit.rd);

endmodule

// ==== verilog/ooo_pkg.sv ====
package ooo_pkg;

    localparam int num_gprs    = 16;
    localparam int tag_field_w = 6;   // tag slot in the structs, up to 64 rob entries

    typedef logic [31:0] gpr_t;
    typedef logic [3:0]  gpr_idx_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_ADDI = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // ************************************************************
    // tag width rule, modules size their tag vectors with this
    // ************************************************************
    function automatic int tag_bits(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

    typedef struct packed {
        op_t      op;
        gpr_idx_t rd;
        gpr_idx_t rs1;
        gpr_idx_t rs2;
        imm_t     imm;   // sign extended for addi
    } instr_t;

    typedef struct packed {
        gpr_t                   value;
        logic                   busy;
        logic [tag_field_w-1:0] tag;   // rob entry that will write this reg
    } gpr_entry;

    typedef struct packed {
        op_t                    op;
        gpr_t                   opa;
        gpr_t                   opb;
        logic [tag_field_w-1:0] tag;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        logic [tag_field_w-1:0] tag;
        gpr_t                   value;
    } wb_t;

    typedef struct packed {
        logic                   valid;
        gpr_idx_t               rd;
        logic [tag_field_w-1:0] tag;
        gpr_t                   value;
    } commit_t;

endpackage
